/* source/aluPkg.sv */
package aluPkg;

    // Data path widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  tag_t;

    // Zero count spans 0 to 32
    typedef logic [5:0]  count_t;

    // Twenty operations, widened select
    typedef enum logic [4:0] {
        OpAdd   = 5'd0,
        OpSub   = 5'd1,
        OpAnd   = 5'd2,
        OpOr    = 5'd3,
        OpXor   = 5'd4,
        OpNor   = 5'd5,
        OpNand  = 5'd6,
        OpSll   = 5'd7,
        OpSrl   = 5'd8,
        OpSra   = 5'd9,
        OpPassB = 5'd10,
        OpMul   = 5'd11,
        OpDiv   = 5'd12,
        OpMax   = 5'd13,
        OpMin   = 5'd14,
        OpClz   = 5'd15,
        OpCtz   = 5'd16,
        OpRot   = 5'd17,
        OpSlt   = 5'd18,
        OpSltu  = 5'd19
    } aluOp_e;

    // Flags of the add/subtract path
    typedef struct packed {
        logic carry;
        logic zero;
        logic overflow;
        logic sign;
    } aluFlags_t;

    typedef struct packed {
        tag_t   tag;
        aluOp_e op;
        word_t  a;
        word_t  b;
        shamt_t shamt;
    } aluReq_t;

    typedef struct packed {
        tag_t      tag;
        word_t     result;
        aluFlags_t flags;
    } aluRsp_t;

endpackage

/* source/zeroCounter.sv */
`timescale 1ns/1ps

module zeroCounter (
    input  aluPkg::word_t  word,
    input  logic           trailing,
    output aluPkg::count_t count
);

    localparam int Width = $bits(aluPkg::word_t);

    logic found;

    // Priority scan, first set bit wins
    always_comb begin
        count = aluPkg::count_t'(Width);
        found = 1'b0;
        for (int i = 0; i < Width; i++) begin
            // Walk up from bit 0 for CTZ, down from the top for CLZ
            if (!found && word[trailing ? i : Width - 1 - i]) begin
                count = aluPkg::count_t'(i);
                found = 1'b1;
            end
        end
    end

endmodule

/* source/aluCore.sv */
`timescale 1ns/1ps

module aluCore (
    input  aluPkg::aluReq_t   req,
    output aluPkg::word_t     result,
    output aluPkg::aluFlags_t flags
);

    aluPkg::word_t  a;
    aluPkg::word_t  b;
    aluPkg::word_t  addRes;
    aluPkg::count_t zeroCount;
    logic [32:0]    sum33;
    logic           isAdd;
    logic           isSub;
    logic           isCtz;

    // Left rotate, zero amount keeps the operand
    function automatic aluPkg::word_t rotl(
        input aluPkg::word_t  val,
        input aluPkg::shamt_t sh
    );
        aluPkg::word_t rotated;
        if (sh == '0) begin
            rotated = val;
        end else begin
            rotated = (val << sh) | (val >> (6'd32 - {1'b0, sh}));
        end
        return rotated;
    endfunction

    assign a     = req.a;
    assign b     = req.b;
    assign isAdd = (req.op == aluPkg::OpAdd);
    assign isSub = (req.op == aluPkg::OpSub);
    assign isCtz = (req.op == aluPkg::OpCtz);

    // Shared adder, subtracts only for SUB
    assign sum33  = isSub ? ({1'b0, a} + {1'b0, ~b} + 33'd1)
                          : ({1'b0, a} + {1'b0, b});
    assign addRes = sum33[31:0];

    // Flags always come from the adder
    assign flags.carry    = sum33[32];
    assign flags.zero     = (addRes == '0);
    assign flags.sign     = addRes[31];
    assign flags.overflow = (isAdd && (a[31] == b[31]) && (addRes[31] != a[31]))
                         || (isSub && (a[31] != b[31]) && (addRes[31] != a[31]));

    zeroCounter u_zeroCounter (
        .word     (a),
        .trailing (isCtz),
        .count    (zeroCount)
    );

    always_comb begin
        case (req.op)
            aluPkg::OpAdd:   result = addRes;
            aluPkg::OpSub:   result = addRes;
            aluPkg::OpAnd:   result = a & b;
            aluPkg::OpOr:    result = a | b;
            aluPkg::OpXor:   result = a ^ b;
            aluPkg::OpNor:   result = ~(a | b);
            aluPkg::OpNand:  result = ~(a & b);
            aluPkg::OpSll:   result = a << req.shamt;
            aluPkg::OpSrl:   result = a >> req.shamt;
            aluPkg::OpSra:   result = aluPkg::word_t'($signed(a) >>> req.shamt);
            aluPkg::OpPassB: result = b;
            // Low word of the unsigned product
            aluPkg::OpMul:   result = a * b;
            aluPkg::OpDiv:   result = (b != '0) ? a / b : '0;
            aluPkg::OpMax:   result = (a > b) ? a : b;
            aluPkg::OpMin:   result = (a < b) ? a : b;
            aluPkg::OpClz:   result = aluPkg::word_t'(zeroCount);
            aluPkg::OpCtz:   result = aluPkg::word_t'(zeroCount);
            aluPkg::OpRot:   result = rotl(a, req.shamt);
            aluPkg::OpSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluPkg::OpSltu:  result = (a < b) ? 32'd1 : 32'd0;
            // Encodings 20 to 31 are unused
            default:         result = '0;
        endcase
    end

endmodule

/* source/requestQueue.sv */
`timescale 1ns/1ps

module requestQueue #(
    parameter int QueueDepth = 4
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            reqValid,
    input  aluPkg::aluReq_t req,
    input  logic            pop,
    output aluPkg::aluReq_t head,
    output logic            headValid,
    output logic            reqCredit
);

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);
    localparam logic [PtrW-1:0] LastIdx = PtrW'(QueueDepth - 1);

    aluPkg::aluReq_t mem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    assign head      = mem[rdPtr];
    assign headValid = (count != '0);

    // Each entry leaving hands one credit back upstream
    assign reqCredit = pop;

    // Issuer credits guarantee a free slot
    always_ff @(posedge clk) begin
        if (reqValid) begin
            mem[wrPtr] <= req;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (reqValid) begin
                wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
            end
            case ({reqValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/resultIssue.sv */
`timescale 1ns/1ps

module resultIssue #(
    parameter int RspCredits = 2
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              headValid,
    input  aluPkg::tag_t      headTag,
    input  aluPkg::word_t     result,
    input  aluPkg::aluFlags_t flags,
    input  logic              rspCredit,
    output logic              pop,
    output logic              rspValid,
    output aluPkg::aluRsp_t   rsp
);

    localparam int CntW = $clog2(RspCredits + 1);

    logic [CntW-1:0] credits;

    // A credit arriving this cycle can be spent at once
    assign pop = headValid && ((credits != '0) || rspCredit);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits  <= CntW'(RspCredits);
            rspValid <= 1'b0;
        end else begin
            rspValid <= pop;
            case ({rspCredit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                // Gain and spend cancel out
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsp.tag    <= headTag;
            rsp.result <= result;
            rsp.flags  <= flags;
        end
    end

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit #(
    parameter int QueueDepth = 4,
    parameter int RspCredits = 2
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            reqValid,
    input  aluPkg::aluReq_t req,
    output logic            reqCredit,
    output logic            rspValid,
    output aluPkg::aluRsp_t rsp,
    input  logic            rspCredit
);

    aluPkg::aluReq_t   head;
    aluPkg::word_t     result;
    aluPkg::aluFlags_t flags;
    logic              headValid;
    logic              pop;

    requestQueue #(
        .QueueDepth (QueueDepth)
    ) u_requestQueue (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .pop       (pop),
        .head      (head),
        .headValid (headValid),
        .reqCredit (reqCredit)
    );

    // Head of queue is evaluated in the same cycle it is popped
    aluCore u_aluCore (
        .req    (head),
        .result (result),
        .flags  (flags)
    );

    resultIssue #(
        .RspCredits (RspCredits)
    ) u_resultIssue (
        .clk       (clk),
        .rstN      (rstN),
        .headValid (headValid),
        .headTag   (head.tag),
        .result    (result),
        .flags     (flags),
        .rspCredit (rspCredit),
        .pop       (pop),
        .rspValid  (rspValid),
        .rsp       (rsp)
    );

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int Period      = 20,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the rising sampling edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* test/aluRefModel.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Expected response of one request, worked out from the operation rules
function automatic aluPkg::aluRsp_t refModel(input aluPkg::aluReq_t r);
    aluPkg::aluRsp_t rsp;
    aluPkg::word_t   v;
    logic [32:0]     sum;
    logic [63:0]     prod;
    longint          sa;
    longint          sb;
    longint          exact;
    logic            isSub;
    int              n;
    isSub = (r.op == aluPkg::OpSub);
    // Subtraction is a + ~b + 1, so carry means no borrow
    sum   = {1'b0, r.a} + {1'b0, (isSub ? ~r.b : r.b)} + 33'(isSub);
    sa    = $signed(r.a);
    sb    = $signed(r.b);
    exact = isSub ? sa - sb : sa + sb;
    n     = 0;
    case (r.op)
        aluPkg::OpAdd, aluPkg::OpSub: v = sum[31:0];
        aluPkg::OpAnd:   v = r.a & r.b;
        aluPkg::OpOr:    v = r.a | r.b;
        aluPkg::OpXor:   v = r.a ^ r.b;
        aluPkg::OpNor:   v = ~(r.a | r.b);
        aluPkg::OpNand:  v = ~(r.a & r.b);
        aluPkg::OpSll:   v = r.a << r.shamt;
        aluPkg::OpSrl:   v = r.a >> r.shamt;
        aluPkg::OpSra: begin
            v = r.a;
            repeat (r.shamt) v = {v[31], v[31:1]};
        end
        aluPkg::OpPassB: v = r.b;
        aluPkg::OpMul: begin
            prod = {32'd0, r.a} * {32'd0, r.b};
            v    = prod[31:0];
        end
        aluPkg::OpDiv:   v = (r.b == 0) ? 32'd0 : r.a / r.b;
        aluPkg::OpMax:   v = (r.a >= r.b) ? r.a : r.b;
        aluPkg::OpMin:   v = (r.a <= r.b) ? r.a : r.b;
        aluPkg::OpClz: begin
            while (n < 32 && !r.a[31 - n]) n++;
            v = n;
        end
        aluPkg::OpCtz: begin
            while (n < 32 && !r.a[n]) n++;
            v = n;
        end
        aluPkg::OpRot: begin
            v = r.a;
            repeat (r.shamt) v = {v[30:0], v[31]};
        end
        aluPkg::OpSlt:   v = {31'd0, ($signed(r.a) < $signed(r.b))};
        aluPkg::OpSltu:  v = {31'd0, (r.a < r.b)};
        default:         v = 32'd0;
    endcase
    rsp.tag            = r.tag;
    rsp.result         = v;
    rsp.flags.carry    = sum[32];
    rsp.flags.zero     = (sum[31:0] == 0);
    rsp.flags.sign     = sum[31];
    // Overflow when the exact signed sum does not fit in 32 bits
    rsp.flags.overflow = (r.op == aluPkg::OpAdd || isSub)
                      && (exact != longint'($signed(sum[31:0])));
    return rsp;
endfunction

`endif

/* test/aluUnitTb.sv */
`timescale 1ns/1ps

module aluUnitTb;

    `include "aluRefModel.svh"

    localparam int QueueDepth = 4;
    localparam int RspCredits = 2;
    localparam int NumRows    = 32;
    localparam int NumRandom  = 200;
    // Table, one lone request, eight in order, six under back-pressure, random
    localparam int TotalReqs  = NumRows + 1 + 8 + 6 + NumRandom;
    localparam int CycleLimit = 8 * TotalReqs + 200;

    typedef struct packed {
        logic [79:0]       name;
        aluPkg::aluOp_e    op;
        aluPkg::word_t     a;
        aluPkg::word_t     b;
        aluPkg::shamt_t    shamt;
        aluPkg::word_t     result;
        aluPkg::aluFlags_t flags;
    } row_t;

    // Flags are carry, zero, overflow, sign
    row_t rows [NumRows] = '{
        '{"add ovf",   aluPkg::OpAdd,   32'h7fff_ffff, 32'h1, 5'd0, 32'h8000_0000, 4'b0011},
        '{"add carry", aluPkg::OpAdd,   32'hffff_ffff, 32'h1, 5'd0, 32'h0, 4'b1100},
        '{"sub ovf",   aluPkg::OpSub,   32'h8000_0000, 32'h1, 5'd0, 32'h7fff_ffff, 4'b1010},
        '{"sub zero",  aluPkg::OpSub,   32'h5, 32'h5, 5'd0, 32'h0, 4'b1100},
        '{"sub neg",   aluPkg::OpSub,   32'h3, 32'h5, 5'd0, 32'hffff_fffe, 4'b0001},
        '{"and",       aluPkg::OpAnd,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd0, 32'h00f0_00f0, 4'b1000},
        '{"or",        aluPkg::OpOr,    32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd0, 32'hfff0_fff0, 4'b1000},
        '{"xor",       aluPkg::OpXor,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd0, 32'hff00_ff00, 4'b1000},
        '{"nor",       aluPkg::OpNor,   32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd0, 32'h000f_000f, 4'b1000},
        '{"nand",      aluPkg::OpNand,  32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd0, 32'hff0f_ff0f, 4'b1000},
        '{"passb",     aluPkg::OpPassB, 32'h0, 32'hdead_beef, 5'd0, 32'hdead_beef, 4'b0001},
        '{"sll 0",     aluPkg::OpSll,   32'h8000_0001, 32'h0, 5'd0, 32'h8000_0001, 4'b0001},
        '{"sll 31",    aluPkg::OpSll,   32'h3, 32'h0, 5'd31, 32'h8000_0000, 4'b0000},
        '{"srl 0",     aluPkg::OpSrl,   32'h8000_0001, 32'h0, 5'd0, 32'h8000_0001, 4'b0001},
        '{"srl 31",    aluPkg::OpSrl,   32'h8000_0001, 32'h0, 5'd31, 32'h1, 4'b0001},
        '{"sra 0",     aluPkg::OpSra,   32'h8000_0000, 32'h0, 5'd0, 32'h8000_0000, 4'b0001},
        '{"sra 31",    aluPkg::OpSra,   32'h8000_0000, 32'h0, 5'd31, 32'hffff_ffff, 4'b0001},
        '{"mul",       aluPkg::OpMul,   32'hffff_ffff, 32'h2, 5'd0, 32'hffff_fffe, 4'b1000},
        '{"div",       aluPkg::OpDiv,   32'h64, 32'h7, 5'd0, 32'he, 4'b0000},
        '{"div zero",  aluPkg::OpDiv,   32'h1234_5678, 32'h0, 5'd0, 32'h0, 4'b0000},
        '{"max",       aluPkg::OpMax,   32'h8000_0000, 32'h7fff_ffff, 5'd0, 32'h8000_0000, 4'b0001},
        '{"min",       aluPkg::OpMin,   32'h8000_0000, 32'h7fff_ffff, 5'd0, 32'h7fff_ffff, 4'b0001},
        '{"clz zero",  aluPkg::OpClz,   32'h0, 32'h0, 5'd0, 32'd32, 4'b0100},
        '{"clz one",   aluPkg::OpClz,   32'h1, 32'h0, 5'd0, 32'd31, 4'b0000},
        '{"clz top",   aluPkg::OpClz,   32'h8000_0000, 32'h0, 5'd0, 32'd0, 4'b0001},
        '{"ctz zero",  aluPkg::OpCtz,   32'h0, 32'h0, 5'd0, 32'd32, 4'b0100},
        '{"ctz one",   aluPkg::OpCtz,   32'h1, 32'h0, 5'd0, 32'd0, 4'b0000},
        '{"ctz top",   aluPkg::OpCtz,   32'h8000_0000, 32'h0, 5'd0, 32'd31, 4'b0001},
        '{"rot 0",     aluPkg::OpRot,   32'h1234_5678, 32'h0, 5'd0, 32'h1234_5678, 4'b0000},
        '{"rot 8",     aluPkg::OpRot,   32'h1234_5678, 32'h0, 5'd8, 32'h3456_7812, 4'b0000},
        '{"slt",       aluPkg::OpSlt,   32'hffff_ffff, 32'h1, 5'd0, 32'h1, 4'b1100},
        '{"sltu",      aluPkg::OpSltu,  32'hffff_ffff, 32'h1, 5'd0, 32'h0, 4'b1100}
    };

    logic            clk;
    logic            rstN;
    logic            reqValid;
    logic            reqCredit;
    logic            rspValid;
    logic            rspCredit;
    aluPkg::aluReq_t req;
    aluPkg::aluRsp_t rsp;

    // Scoreboard and credit bookkeeping
    aluPkg::aluRsp_t expQ [$];
    string           nameQ [$];
    int              issuerCredits = QueueDepth;
    int              owed = 0;
    int              cycle = 0;
    int              errors = 0;
    int              passTests = 0;
    int              failTests = 0;
    int              rspCount = 0;
    int              creditPulses = 0;
    int              lastRspCycle = 0;
    int              latencyEdge = -100;
    logic            latencyArmed = 1'b0;
    logic            holdCredits = 1'b0;
    logic            randomGaps = 1'b0;
    logic [31:0]     lfsrState = 32'he114_3dc4;
    logic [31:0]     gapState = 32'he114_3dc4;

    clockGen u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    aluUnit #(
        .QueueDepth (QueueDepth),
        .RspCredits (RspCredits)
    ) u_aluUnit (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .reqCredit (reqCredit),
        .rspValid  (rspValid),
        .rsp       (rsp),
        .rspCredit (rspCredit)
    );

    // Feedback mask of a 32-bit Galois LFSR
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val       = {val[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic issue(input string name, input aluPkg::aluReq_t r,
                         input aluPkg::aluRsp_t exp);
        while (issuerCredits == 0) @(negedge clk);
        req      = r;
        reqValid = 1'b1;
        issuerCredits--;
        expQ.push_back(exp);
        nameQ.push_back(name);
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    // Mode changes land on the rising edge, read by the credit driver on the falling one
    task automatic setCredits(input logic hold, input logic gaps);
        @(posedge clk);
        holdCredits = hold;
        randomGaps  = gaps;
        @(negedge clk);
    endtask

    task automatic drain();
        while (expQ.size() != 0 || owed != 0) @(negedge clk);
    endtask

    task automatic report(input string name, input int errStart);
        if (errors == errStart) begin
            $display("test %s: ok", name);
            passTests++;
        end else begin
            $display("test %s: %0d errors", name, errors - errStart);
            failTests++;
        end
    endtask

    // Receiver side, one credit back per response
    always @(negedge clk) begin
        rspCredit = 1'b0;
        if (!holdCredits && owed > 0) begin
            if (!randomGaps) begin
                rspCredit = 1'b1;
            end else begin
                rspCredit = gapState[0];
                gapState  = lfsrNext(gapState);
            end
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            cycle++;
            if (reqCredit) begin
                issuerCredits++;
                creditPulses++;
            end
            if (rspCredit) owed--;
            if (latencyArmed && reqValid) latencyEdge = cycle;
            if (latencyArmed && reqCredit) compare("credit latency", latencyEdge + 1, cycle);
            if (rspValid) begin
                rspCount++;
                lastRspCycle = cycle;
                owed++;
                if (latencyArmed) begin
                    compare("response latency", latencyEdge + 2, cycle);
                    latencyArmed = 1'b0;
                end
                if (expQ.size() == 0) begin
                    $display("unexpected response with tag %h, nothing outstanding", rsp.tag);
                    errors++;
                end else begin
                    compare(nameQ.pop_front(), expQ.pop_front(), rsp);
                end
            end
            if (cycle > CycleLimit) begin
                $display("timeout after %0d cycles, responses still missing", CycleLimit);
                $display("sim failed");
                $finish;
            end
        end
    end

    initial begin
        row_t            row;
        aluPkg::aluReq_t r;
        aluPkg::aluRsp_t exp;
        logic [31:0]     bits;
        int              errStart;
        int              firstEdge;
        int              rspMark;
        int              pulseMark;
        reqValid  = 1'b0;
        req       = '0;
        rspCredit = 1'b0;
        @(posedge rstN);
        @(negedge clk);

        errStart = errors;
        for (int i = 0; i < NumRows; i++) begin
            row        = rows[i];
            r.tag      = aluPkg::tag_t'(i);
            r.op       = row.op;
            r.a        = row.a;
            r.b        = row.b;
            r.shamt    = row.shamt;
            exp.tag    = r.tag;
            exp.result = row.result;
            exp.flags  = row.flags;
            issue($sformatf("%0s", row.name), r, exp);
        end
        drain();
        report("table operations", errStart);

        errStart     = errors;
        latencyArmed = 1'b1;
        r            = '{tag: 4'ha, op: aluPkg::OpAdd, a: 32'd1, b: 32'd2, shamt: 5'd0};
        issue("lone add", r, refModel(r));
        drain();
        report("fixed latency", errStart);

        errStart  = errors;
        firstEdge = cycle + 1;
        for (int i = 0; i < 8; i++) begin
            r = '{tag: aluPkg::tag_t'(i + 3), op: aluPkg::OpAdd, a: i, b: 32'd100, shamt: 5'd0};
            issue($sformatf("order %0d", i), r, refModel(r));
        end
        drain();
        // Eight back-to-back items leave on consecutive cycles
        compare("order span", firstEdge + 9, lastRspCycle);
        report("order and tags", errStart);

        errStart = errors;
        setCredits(1'b1, 1'b0);
        rspMark = rspCount;
        for (int i = 0; i < 6; i++) begin
            r = '{tag: aluPkg::tag_t'(i + 1), op: aluPkg::OpSub, a: 1000 * i, b: i, shamt: 5'd0};
            issue($sformatf("held %0d", i), r, refModel(r));
        end
        while (rspCount - rspMark < 2) @(negedge clk);
        pulseMark = creditPulses;
        repeat (12) @(negedge clk);
        compare("held responses", 2, rspCount - rspMark);
        compare("issuer credits", 0, issuerCredits);
        compare("held credit pulses", 0, creditPulses - pulseMark);
        setCredits(1'b0, 1'b0);
        drain();
        report("back-pressure", errStart);

        errStart = errors;
        setCredits(1'b0, 1'b1);
        for (int i = 0; i < NumRandom; i++) begin
            takeBits(5, bits);
            r.op = aluPkg::aluOp_e'(bits[4:0] % 20);
            takeBits(32, bits);
            r.a = bits;
            takeBits(32, bits);
            r.b = bits;
            takeBits(5, bits);
            r.shamt = bits[4:0];
            takeBits(4, bits);
            r.tag = bits[3:0];
            takeBits(1, bits);
            if (bits[0]) @(negedge clk);
            issue($sformatf("random %0d", i), r, refModel(r));
        end
        drain();
        setCredits(1'b0, 1'b0);
        compare("response count", TotalReqs, rspCount);
        report("random requests", errStart);

        $display("tests ok %0d, tests with errors %0d, failed checks %0d",
                 passTests, failTests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+test
source/aluPkg.sv
source/zeroCounter.sv
source/aluCore.sv
source/requestQueue.sv
source/resultIssue.sv
source/aluUnit.sv
test/clockGen.sv
test/aluUnitTb.sv
